// ==== cpu_pkg.sv ====
// ==============================
// Core types for the 32-bit CPU. Opcode sits in instr[31:24]
// Codes not listed in opcode_e execute as nop
// ==============================
package cpu_pkg;

  localparam int num_regs = 4;
  localparam int word_w   = 32;

  typedef logic [word_w-1:0]           word_t;
  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

  // Opcode byte values
  typedef enum logic [7:0] {
    op_nop  = 8'h00,
    op_li   = 8'h01,
    op_add  = 8'h02,
    op_sub  = 8'h03,
    op_and  = 8'h04,
    op_or   = 8'h05,
    op_xor  = 8'h06,
    op_ld   = 8'h07,
    op_st   = 8'h08,
    op_jmp  = 8'h09,
    op_halt = 8'h0f
  } opcode_e;

  // Instruction word, top bit first
  typedef struct packed {
    logic [7:0]  opcode;
    reg_idx_t    rd;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [1:0]  spare;  // Must be zero
    logic [15:0] imm;
  } instr_t;

  localparam word_t pc_step = 32'd4;  // Byte addressed, one word per instruction

endpackage

// ==== bus_pkg.sv ====
// ==============================
// Pin bus frame: 1 command, 4 address, 4 data beats
// No wait states and no error reporting
// ==============================
package bus_pkg;

  localparam int frame_beats     = 9;
  localparam int beat_cnt_w      = $clog2(frame_beats);
  localparam int addr_first_beat = 1;
  localparam int data_first_beat = 5;

  // Command byte layout, other bits zero
  localparam int cmd_start_bit = 7;
  localparam int cmd_write_bit = 6;

  typedef struct packed {
    logic           valid;  // One cycle strobe
    logic           write;
    cpu_pkg::word_t addr;
    cpu_pkg::word_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic           done;   // Pulses after the last beat
    cpu_pkg::word_t rdata;  // Held until the next request
  } bus_rsp_t;

endpackage

// ==== cpu_alu.sv ====
// ==============================
// Combinational ALU, zero for opcodes with no result
// Immediate is always zero-extended
// ==============================
`timescale 1ns/1ps

module cpu_alu (
  input  cpu_pkg::opcode_e op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  logic [15:0]      imm,
  output cpu_pkg::word_t   result
);
  import cpu_pkg::*;

  word_t imm_ext;

  assign imm_ext = word_t'(imm);

  always_comb begin
    case (op)
      op_li:        result = imm_ext;
      op_add:       result = a + b;
      op_sub:       result = a - b;
      op_and:       result = a & b;
      op_or:        result = a | b;
      op_xor:       result = a ^ b;
      op_ld, op_st: result = a + imm_ext;  // Effective address
      default:      result = '0;
    endcase
  end

endmodule

// ==== cpu_regfile.sv ====
// ==============================
// Four registers, two async reads
// ==============================
`timescale 1ns/1ps

module cpu_regfile (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::reg_idx_t raddr_a,
  input  cpu_pkg::reg_idx_t raddr_b,
  output cpu_pkg::word_t    rdata_a,
  output cpu_pkg::word_t    rdata_b,
  input  logic              we,
  input  cpu_pkg::reg_idx_t waddr,
  input  cpu_pkg::word_t    wdata
);
  import cpu_pkg::*;

  word_t regs [num_regs];

  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

  // Write lands at the clock edge, reads see it the cycle after
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// ==== cpu_ctrl.sv ====
// ==============================
// Multi-cycle control, one instruction at a time
// run is sampled only before a fetch; halt holds until reset
// ==============================
`timescale 1ns/1ps

module cpu_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,
  output bus_pkg::bus_req_t bus_req,
  input  bus_pkg::bus_rsp_t bus_rsp,
  output cpu_pkg::reg_idx_t rf_raddr_a,
  output cpu_pkg::reg_idx_t rf_raddr_b,
  input  cpu_pkg::word_t    rf_rdata_a,
  input  cpu_pkg::word_t    rf_rdata_b,
  output logic              rf_we,
  output cpu_pkg::reg_idx_t rf_waddr,
  output cpu_pkg::word_t    rf_wdata,
  output cpu_pkg::opcode_e  alu_op,
  output logic [15:0]       alu_imm,
  input  cpu_pkg::word_t    alu_result
);
  import cpu_pkg::*;
  import bus_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_decode,
    st_exec,
    st_mem,
    st_halt
  } state_e;

  state_e   state;
  word_t    pc;
  instr_t   ir;
  opcode_e  op;
  logic     is_store;
  logic     is_mem;
  logic     writes_reg;
  bus_req_t req_q;
  logic     outstanding;  // Frame in flight on the pin bus

  assign op       = opcode_e'(ir.opcode);
  assign is_store = (op == op_st);
  assign is_mem   = (op == op_ld) || is_store;

  always_comb begin
    case (op)
      op_li, op_add, op_sub, op_and, op_or, op_xor: writes_reg = 1'b1;
      default:                                      writes_reg = 1'b0;
    endcase
  end

  assign rf_raddr_a = ir.rs;
  assign rf_raddr_b = ir.rt;  // Also the store data source
  assign rf_waddr   = ir.rd;
  assign alu_op     = op;
  assign alu_imm    = ir.imm;
  assign bus_req    = req_q;

  // Write back ALU results in exec, load data when the frame ends
  assign rf_we    = ((state == st_exec) && writes_reg) ||
                    ((state == st_mem) && bus_rsp.done && (op == op_ld));
  assign rf_wdata = (state == st_mem) ? bus_rsp.rdata : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      pc    <= '0;
      req_q <= '0;
    end else begin
      req_q.valid <= 1'b0;  // Strobe lasts a single cycle
      case (state)
        st_idle: begin
          if (run) begin
            req_q <= '{valid: 1'b1, write: 1'b0, addr: pc, wdata: '0};
            state <= st_fetch;
          end
        end
        st_fetch: begin
          if (bus_rsp.done) state <= st_decode;
        end
        st_decode: begin
          if (op == op_halt) begin
            state <= st_halt;  // pc keeps the halt address
          end else if (is_mem) begin
            req_q <= '{valid: 1'b1, write: is_store, addr: alu_result, wdata: rf_rdata_b};
            state <= st_mem;
          end else begin
            state <= st_exec;
          end
        end
        st_exec: begin
          pc    <= (op == op_jmp) ? word_t'(ir.imm) : pc + pc_step;
          state <= st_idle;
        end
        st_mem: begin
          if (bus_rsp.done) begin
            pc    <= pc + pc_step;
            state <= st_idle;
          end
        end
        st_halt: state <= st_halt;
        default: state <= st_idle;
      endcase
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if ((state == st_fetch) && bus_rsp.done) ir <= instr_t'(bus_rsp.rdata);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
    end else if (req_q.valid) begin
      outstanding <= 1'b1;
    end else if (bus_rsp.done) begin
      outstanding <= 1'b0;
    end
  end

  a_one_frame: assert property (@(posedge clk) disable iff (rst)
    req_q.valid |-> !outstanding)
    else $error("request issued while a frame is outstanding");

endmodule

// ==== bus_handler.sv ====
// ==============================
// Nine beat pin frame per request, no back-pressure
// Read bytes must be valid on uio_in during beats 5 to 8
// ==============================
`timescale 1ns/1ps

module bus_handler (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req,
  output bus_pkg::bus_rsp_t rsp,
  output logic [7:0]        uo_out,
  output logic [7:0]        uio_out,
  input  logic [7:0]        uio_in,
  output logic [7:0]        uio_oe
);
  import cpu_pkg::*;
  import bus_pkg::*;

  bus_req_t              cur;  // Request held for the whole frame
  logic                  busy;
  logic [beat_cnt_w-1:0] beat;
  logic [1:0]            byte_idx;
  logic                  in_addr;
  logic                  in_data;
  logic [7:0]            cmd_byte;
  logic                  done_q;
  word_t                 rdata_q;

  // Beats 1..4 and 5..8 both map to bytes 0..3
  assign byte_idx = beat[1:0] - 2'd1;
  assign in_addr  = busy && (beat >= beat_cnt_w'(addr_first_beat)) &&
                    (beat < beat_cnt_w'(data_first_beat));
  assign in_data  = busy && (beat >= beat_cnt_w'(data_first_beat));

  always_comb begin
    cmd_byte                = '0;
    cmd_byte[cmd_start_bit] = 1'b1;
    cmd_byte[cmd_write_bit] = cur.write;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      beat   <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!busy) begin
        if (req.valid) begin
          busy <= 1'b1;
          beat <= '0;
        end
      end else if (beat == beat_cnt_w'(frame_beats - 1)) begin
        busy   <= 1'b0;
        done_q <= 1'b1;
      end else begin
        beat <= beat + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && req.valid) cur <= req;
    if (in_data && !cur.write) rdata_q <= {uio_in, rdata_q[31:8]};  // LSB arrives first
  end

  assign rsp = '{done: done_q, rdata: rdata_q};

  // Pins rest at zero between frames
  always_comb begin
    uo_out  = '0;
    uio_out = '0;
    uio_oe  = '0;
    if (busy && (beat == '0)) begin
      uo_out = cmd_byte;
    end else if (in_addr) begin
      uo_out = cur.addr[8*byte_idx +: 8];
    end
    if (in_data && cur.write) begin
      uio_out = cur.wdata[8*byte_idx +: 8];
      uio_oe  = '1;
    end
  end

  a_req_idle: assert property (@(posedge clk) disable iff (rst)
    req.valid |-> !busy)
    else $error("bus request while a frame is running");

  a_oe_whole: assert property (@(posedge clk) disable iff (rst)
    uio_oe inside {8'h00, 8'hff})
    else $error("uio_oe split between input and output");

endmodule

// ==== cpu_top.sv ====
// ==============================
// Tile top with ui_in[0] as the run level
// Memory is external on the pin bus
// ==============================
`timescale 1ns/1ps

module cpu_top (
  input  logic       clk,
  input  logic       rst,
  input  logic       ena,
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);
  import cpu_pkg::*;
  import bus_pkg::*;

  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  reg_idx_t    rf_raddr_a;
  reg_idx_t    rf_raddr_b;
  word_t       rf_rdata_a;
  word_t       rf_rdata_b;
  logic        rf_we;
  reg_idx_t    rf_waddr;
  word_t       rf_wdata;
  opcode_e     alu_op;
  logic [15:0] alu_imm;
  word_t       alu_result;
  logic        run;
  logic        unused_inputs;

  assign run           = ui_in[0];
  assign unused_inputs = &{ena, ui_in[7:1]};

  cpu_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .rf_raddr_a (rf_raddr_a),
    .rf_raddr_b (rf_raddr_b),
    .rf_rdata_a (rf_rdata_a),
    .rf_rdata_b (rf_rdata_b),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .alu_op     (alu_op),
    .alu_imm    (alu_imm),
    .alu_result (alu_result)
  );

  cpu_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .raddr_a (rf_raddr_a),
    .raddr_b (rf_raddr_b),
    .rdata_a (rf_rdata_a),
    .rdata_b (rf_rdata_b),
    .we      (rf_we),
    .waddr   (rf_waddr),
    .wdata   (rf_wdata)
  );

  cpu_alu u_alu (
    .op     (alu_op),
    .a      (rf_rdata_a),
    .b      (rf_rdata_b),
    .imm    (alu_imm),
    .result (alu_result)
  );

  bus_handler u_bus (
    .clk     (clk),
    .rst     (rst),
    .req     (bus_req),
    .rsp     (bus_rsp),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_in  (uio_in),
    .uio_oe  (uio_oe)
  );

endmodule

// ==== tb_clk_gen.sv ====
// ==============================
// Simulation clock, 8 ns period
// Starts low, first rising edge at 4 ns
// ==============================
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);
  localparam int half_period = 4;  // ns

  initial begin
    clk = 1'b0;
    forever begin
      #(half_period) clk = ~clk;
    end
  end

endmodule

// ==== tb_cpu_top.sv ====
// ==============================
// Plays the external memory on the pin bus, records from mem_input.txt
// Model covers byte addresses below 4 KiB, word aligned only
// ==============================
`timescale 1ns/1ps

module tb_cpu_top;
  import cpu_pkg::*;

  localparam int drive_dly    = 1;  // ns after the rising edge
  localparam int rst_cycles   = 8;
  localparam int idle_cycles  = 20;
  localparam int run_timeout  = 20000;
  localparam int quiet_cycles = 200;
  localparam int mem_words    = 1024;
  localparam int max_recs     = 64;

  typedef struct packed {
    logic  write;
    word_t addr;
    word_t data;
  } frame_t;

  logic       clk;
  logic       rst;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uo_out;
  logic [7:0] uio_in;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  word_t  recs [max_recs*3];
  word_t  mem [mem_words];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  word_t  ld_addr [$];
  word_t  ld_data [$];
  word_t  halt_addr;
  int     gap_after;
  int     gap_len;
  frame_t cur;
  int     beat;          // Next beat expected, 0 while idle
  logic   data_pending;  // Fetched ld or st still owes a data frame
  logic   halted;
  word_t  next_pc;
  word_t  last_fetch;
  int     n_frames;
  int     n_fetch;
  int     n_store;
  int     n_jmp;
  int     gap_left;
  logic   gap_seen;
  logic   gap_resumed;
  int     err [1:6];

  tb_clk_gen u_clk_gen (.clk(clk));

  cpu_top u_cpu_top (
    .clk     (clk),
    .rst     (rst),
    .ena     (ena),
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  task automatic report_mismatch(input int t, input string msg);
    $display("ERR at %0d ns: %s", $time, msg);
    err[t]++;
  endtask

  task automatic report_failure(input int t, input string msg);
    $display("Test %0d: %s", t, msg);
    err[t]++;
  endtask

  task automatic report_test(input int t, input string name);
    if (err[t] == 0) begin
      $display("test %0d %s: pass", t, name);
    end else begin
      $display("test %0d %s: fail with %0d errors", t, name, err[t]);
    end
  endtask

  // Tag column holds the ASCII code of the record letter
  task automatic load_stimulus();
    word_t tag;
    for (int i = 0; i < max_recs*3; i++) begin
      recs[i] = '0;
    end
    $readmemh("mem_input.txt", recs);
    for (int i = 0; i < max_recs; i++) begin
      tag = recs[3*i];
      case (tag[7:0])
        "M": mem[recs[3*i+1][11:2]] = recs[3*i+2];
        "E": begin
          exp_addr.push_back(recs[3*i+1]);
          exp_data.push_back(recs[3*i+2]);
        end
        "H": halt_addr = recs[3*i+1];
        "G": begin
          gap_after = recs[3*i+1];
          gap_len   = recs[3*i+2];
        end
        default: ;
      endcase
    end
  endtask

  // Sorts a finished frame into fetch, load data or store
  task automatic close_frame();
    word_t      w;
    logic [7:0] op;
    w = mem[cur.addr[11:2]];
    if (cur.write) begin
      if (n_store >= exp_addr.size()) begin
        report_mismatch(3, $sformatf("unexpected store of %h to %h", cur.data, cur.addr));
      end else if (cur.addr != exp_addr[n_store] || cur.data != exp_data[n_store]) begin
        report_mismatch(3, $sformatf("store %0d wrote %h to %h, expected %h to %h", n_store,
                                     cur.data, cur.addr, exp_data[n_store], exp_addr[n_store]));
      end
      mem[cur.addr[11:2]] = cur.data;
      n_store++;
      data_pending = 1'b0;
    end else if (data_pending) begin
      ld_addr.push_back(cur.addr);
      ld_data.push_back(w);
      data_pending = 1'b0;
    end else begin
      n_fetch++;
      if (n_fetch == 1 && cur.addr != 32'd0) begin
        report_mismatch(2, $sformatf("first fetch from %h, expected 0", cur.addr));
      end else if (cur.addr != next_pc) begin
        report_mismatch(5, $sformatf("fetch from %h, expected %h", cur.addr, next_pc));
      end
      if (gap_seen && !gap_resumed) begin
        gap_resumed = 1'b1;
        if (cur.addr != next_pc) begin
          report_mismatch(6, $sformatf("resumed at %h, expected %h", cur.addr, next_pc));
        end
      end
      op         = w[31:24];
      last_fetch = cur.addr;
      next_pc    = (op == op_jmp) ? {16'h0000, w[15:0]} : cur.addr + 32'd4;
      if (op == op_jmp) n_jmp++;
      if (op == op_halt) halted = 1'b1;
      data_pending = (op == op_ld) || (op == op_st);
      if (n_fetch == gap_after) begin
        ui_in[0] = 1'b0;
        gap_left = gap_len;
        gap_seen = 1'b1;
      end
    end
  endtask

  // Called once per cycle, just after the rising edge
  task automatic watch_pins();
    word_t w;
    if (gap_left > 0) begin
      gap_left--;
      if (gap_left == 0) ui_in[0] = 1'b1;
    end
    if (beat == 0) begin
      uio_in = 8'h00;
      if (uio_oe != 8'h00 || uio_out != 8'h00) begin
        report_mismatch(2, "uio pins driven between frames");
      end
      if (uo_out != 8'h00) begin
        if (!uo_out[7] || uo_out[5:0] != 6'd0) begin
          report_mismatch(2, $sformatf("bad command byte %h", uo_out));
        end
        if (n_frames == 0 && uo_out != 8'h80) begin
          report_mismatch(2, $sformatf("first command byte %h, expected 80", uo_out));
        end
        if (gap_left > 0 && !data_pending) begin
          report_mismatch(6, "fetch frame started while run was low");
        end
        cur.write = uo_out[6];
        n_frames++;
        beat = 1;
      end
    end else begin
      if (beat <= 4) begin
        cur.addr[8*(beat-1) +: 8] = uo_out;  // LSB first
      end else begin
        if (uo_out != 8'h00) report_mismatch(2, "uo_out not zero in a data beat");
        if (cur.write) begin
          if (uio_oe != 8'hff) report_mismatch(3, $sformatf("uio_oe %h in a write beat", uio_oe));
          cur.data[8*(beat-5) +: 8] = uio_out;
        end else begin
          if (uio_oe != 8'h00) report_mismatch(2, $sformatf("uio_oe %h in a read beat", uio_oe));
          w      = mem[cur.addr[11:2]];
          uio_in = w[8*(beat-5) +: 8];
        end
      end
      if (beat == 8) begin
        close_frame();
        beat = 0;
      end else begin
        beat++;
      end
    end
  endtask

  always begin
    @(posedge clk);
    #drive_dly;
    if (!rst) watch_pins();
  end

  initial begin
    int   waited;
    int   frames_at_halt;
    int   n_pass;
    int   n_fail;
    logic found;
    rst    = 1'b1;
    ena    = 1'b1;
    ui_in  = 8'h00;
    uio_in = 8'h00;
    {beat, n_frames, n_fetch, n_store, n_jmp, gap_left, gap_after, gap_len} = '0;
    {data_pending, halted, gap_seen, gap_resumed} = '0;
    next_pc   = '0;
    halt_addr = '0;
    for (int t = 1; t <= 6; t++) begin
      err[t] = 0;
    end
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = (word_t'(i) * 32'h9e3779b9) ^ 32'h0badf00d;  // Unloaded words look like noise
    end
    load_stimulus();

    waited = 0;
    while (waited < rst_cycles + idle_cycles) begin
      @(posedge clk);
      #drive_dly;
      if (waited == rst_cycles - 1) rst = 1'b0;
      if (uo_out != 8'h00 || uio_out != 8'h00 || uio_oe != 8'h00) begin
        report_mismatch(1, "pins not zero during reset or with run low");
      end
      waited++;
    end
    report_test(1, "reset");
    ui_in[0] = 1'b1;

    waited = 0;
    while (!halted && waited < run_timeout) begin
      @(posedge clk);
      waited++;
    end
    if (!halted) begin
      report_failure(5, $sformatf("timeout, no halt fetched within %0d cycles", run_timeout));
    end else begin
      frames_at_halt = n_frames;
      waited = 0;
      while (waited < quiet_cycles) begin
        @(posedge clk);
        waited++;
      end
      if (n_frames != frames_at_halt) report_failure(5, "a frame started after halt");
      if (n_jmp == 0) report_failure(5, "no jmp instruction was fetched");
      if (last_fetch != halt_addr) begin
        report_mismatch(5, $sformatf("last fetch %h, expected %h", last_fetch, halt_addr));
      end
      if (n_store != exp_addr.size()) begin
        report_failure(3, $sformatf("%0d stores seen, %0d expected", n_store, exp_addr.size()));
      end
      found = 1'b0;
      for (int j = 0; j < ld_data.size(); j++) begin
        for (int i = 0; i < exp_data.size(); i++) begin
          if (ld_data[j] == exp_data[i] && ld_addr[j] != exp_addr[i] &&
              mem[exp_addr[i][11:2]] == exp_data[i]) begin
            found = 1'b1;
          end
        end
      end
      if (!found) report_failure(4, "no loaded word was stored unchanged at a new address");
      if (!gap_resumed) report_failure(6, "execution did not resume after the run gap");
    end
    report_test(2, "frame format");
    report_test(3, "alu operations");
    report_test(4, "load and store");
    report_test(5, "jump and halt");
    report_test(6, "run gating");

    n_pass = 0;
    n_fail = 0;
    for (int t = 1; t <= 6; t++) begin
      if (err[t] == 0) n_pass++;
      else n_fail++;
    end
    $display("passed: %0d  failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== mem_input.txt ====
// tag  addr  word : tag is ASCII 4d M image, 45 E store, 48 H halt fetch, 47 G run gap
// G record gives the fetch number after which run drops, then the cycles it stays low
4d 00000000 01401234 // li  r1, 0x1234
4d 00000004 01800f0f // li  r2, 0x0f0f
4d 00000008 02d80000 // add r3, r1, r2
4d 0000000c 080c0100 // st  r3 to r0 + 0x100
4d 00000010 03d80000 // sub r3, r1, r2
4d 00000014 080c0104 // st  r3 to r0 + 0x104
4d 00000018 04d80000 // and r3, r1, r2
4d 0000001c 080c0108 // st  r3 to r0 + 0x108
4d 00000020 05d80000 // or  r3, r1, r2
4d 00000024 080c010c // st  r3 to r0 + 0x10c
4d 00000028 06d80000 // xor r3, r1, r2
4d 0000002c 080c0110 // st  r3 to r0 + 0x110
4d 00000030 03e40000 // sub r3, r2, r1 wraps below zero
4d 00000034 080c0114 // st  r3 to r0 + 0x114
4d 00000038 01400200 // li  r1, 0x200
4d 0000003c 07900010 // ld  r2 from r1 + 0x10
4d 00000040 08180020 // st  r2 to r1 + 0x20
4d 00000044 09000060 // jmp 0x60
4d 00000048 01c0dead // skipped by the jump
4d 0000004c 080c0118 // skipped by the jump
4d 00000060 55000000 // unknown opcode runs as nop
4d 00000064 00000000 // nop
4d 00000068 0f000000 // halt
4d 00000210 cafef00d // data word for the load
45 00000100 00002143
45 00000104 00000325
45 00000108 00000204
45 0000010c 00001f3f
45 00000110 00001d3b
45 00000114 fffffcdb
45 00000220 cafef00d
48 00000068 00000000
47 00000005 00000028

// ==== sources.f ====
cpu_pkg.sv
bus_pkg.sv
cpu_alu.sv
cpu_regfile.sv
cpu_ctrl.sv
bus_handler.sv
cpu_top.sv
tb_clk_gen.sv
tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: tt_cpu32

sources:
  - files:
      - cpu_pkg.sv
      - bus_pkg.sv
      - cpu_alu.sv
      - cpu_regfile.sv
      - cpu_ctrl.sv
      - bus_handler.sv
      - cpu_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_cpu_top.sv
